// File: rtl/isaPkg.sv
`default_nettype none

package isaPkg;

   localparam int unsigned wordWidth   = 16;  // data path and instruction word
   localparam int unsigned regIdxWidth = 3;
   localparam int unsigned numRegs     = 8;

   localparam logic [regIdxWidth-1:0] linkReg = 3'd7;  // return address for jal/jalr

   // 5-bit major opcode, bits 15..11
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opSiic  = 5'b00010,  // no exception support here
      opRti   = 5'b00011,
      opJ     = 5'b00100,
      opJr    = 5'b00101,
      opJal   = 5'b00110,
      opJalr  = 5'b00111,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opStu   = 5'b10011,
      opRoli  = 5'b10100,
      opSlli  = 5'b10101,
      opRori  = 5'b10110,
      opSrli  = 5'b10111,
      opLbi   = 5'b11000,
      opBtr   = 5'b11001,
      opShift = 5'b11010,  // rol/sll/ror/srl picked by func
      opArith = 5'b11011,  // add/sub/xor/andn picked by func
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110,
      opSco   = 5'b11111
   } opcodeT;

   localparam logic [wordWidth-1:0] nopWord = 16'h0800;  // opNop with all fields zero

   // one word, three field layouts; J offset is {iTwo.rs, iTwo.imm8}
   typedef union packed {
      struct packed {
         opcodeT                 opcode;
         logic [regIdxWidth-1:0] rs;
         logic [regIdxWidth-1:0] rt;
         logic [regIdxWidth-1:0] rd;
         logic [1:0]             func;
      } r;
      struct packed {
         opcodeT                 opcode;
         logic [regIdxWidth-1:0] rs;
         logic [regIdxWidth-1:0] rd;
         logic [4:0]             imm5;
      } iOne;
      struct packed {
         opcodeT                 opcode;
         logic [regIdxWidth-1:0] rs;
         logic [7:0]             imm8;
      } iTwo;
   } instrT;

endpackage

`default_nettype wire

// File: rtl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

   localparam int unsigned aluOpWidth = 4;
   localparam int unsigned selWidth   = 2;  // width of the small mux selects
   localparam int unsigned brchWidth  = 3;

   // ALU function code
   typedef enum logic [aluOpWidth-1:0] {
      aluAdd  = 4'd0,
      aluSub  = 4'd1,
      aluXor  = 4'd2,
      aluAndn = 4'd3,
      aluRol  = 4'd4,
      aluSll  = 4'd5,
      aluRor  = 4'd6,
      aluSrl  = 4'd7,
      aluSeq  = 4'd8,
      aluSlt  = 4'd9,
      aluSle  = 4'd10,
      aluSco  = 4'd11,  // carry out of rs + rt
      aluBtr  = 4'd12,  // bit reverse of rs
      aluLbi  = 4'd13,
      aluSlbi = 4'd14,
      aluPass = 4'd15   // A straight through
   } aluOpT;

   typedef enum logic [selWidth-1:0] {
      bSrcReg   = 2'd0,
      bSrcImm5  = 2'd1,
      bSrcImm11 = 2'd2,
      bSrcZero  = 2'd3
   } bSrcT;

   typedef enum logic [selWidth-1:0] {
      wbAlu  = 2'd0,
      wbMem  = 2'd1,
      wbPc2  = 2'd2,  // pc + 2 for jal/jalr
      wbCond = 2'd3   // set-on-condition result
   } wbSelT;

   // where the destination index comes from
   typedef enum logic [selWidth-1:0] {
      destRs   = 2'd0,  // bits 10..8
      destRt   = 2'd1,  // bits 7..5
      destRd   = 2'd2,  // bits 4..2
      destLink = 2'd3
   } destSelT;

   typedef enum logic [brchWidth-1:0] {
      brNone = 3'd0,
      brEqz  = 3'd1,
      brNez  = 3'd2,
      brLtz  = 3'd3,
      brGez  = 3'd4
   } brchT;

endpackage

`default_nettype wire

// File: rtl/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
   input  isaPkg::instrT    instr,
   output ctrlPkg::aluOpT   aluOp,
   output ctrlPkg::bSrcT    bSrc,
   output ctrlPkg::wbSelT   wbSel,
   output ctrlPkg::destSelT destSel,
   output ctrlPkg::brchT    brchSig,
   output logic             zeroExt,     // zero extend imm5/imm8
   output logic             regWrt,
   output logic             memWrt,
   output logic             readEn,
   output logic             memAccess,
   output logic             stuSel,      // store data from rt instead of inB
   output logic             cin,
   output logic             invA,
   output logic             invB,
   output logic             aluJmp,      // jump target computed from rs
   output logic             immSrc,      // pc offset, 1 = imm8, 0 = imm11
   output logic             jalSel,
   output logic             slbiSel,
   output logic             createDump,
   output logic             branchInst,
   output logic             err
);

   import isaPkg::*;
   import ctrlPkg::*;

   always_comb begin
      // defaults describe a nop
      aluOp      = aluPass;
      bSrc       = bSrcReg;
      wbSel      = wbAlu;
      destSel    = destRd;
      brchSig    = brNone;
      zeroExt    = 1'b0;
      regWrt     = 1'b0;
      memWrt     = 1'b0;
      readEn     = 1'b0;
      memAccess  = 1'b0;
      stuSel     = 1'b0;
      cin        = 1'b0;
      invA       = 1'b0;
      invB       = 1'b0;
      aluJmp     = 1'b0;
      immSrc     = 1'b0;
      jalSel     = 1'b0;
      slbiSel    = 1'b0;
      createDump = 1'b0;
      branchInst = 1'b0;
      err        = 1'b0;

      case (instr.r.opcode)
         opHalt: createDump = 1'b1;
         opNop: ;                           // defaults already idle
         opSiic, opRti: err = 1'b1;         // unsupported, write enables stay low

         // immediate arithmetic, rd in bits 7..5
         opAddi, opSubi, opXori, opAndni,
         opRoli, opSlli, opRori, opSrli: begin
            bSrc    = bSrcImm5;
            destSel = destRt;
            regWrt  = 1'b1;
            case (instr.r.opcode)
               opAddi:  aluOp = aluAdd;
               opSubi: begin
                  aluOp = aluSub;           // imm - rs
                  invA  = 1'b1;
                  cin   = 1'b1;
               end
               opXori: begin
                  aluOp   = aluXor;
                  zeroExt = 1'b1;
               end
               opAndni: begin
                  aluOp   = aluAndn;
                  invB    = 1'b1;
                  zeroExt = 1'b1;
               end
               opRoli:  aluOp = aluRol;
               opSlli:  aluOp = aluSll;
               opRori:  aluOp = aluRor;
               default: aluOp = aluSrl;
            endcase
         end

         // memory, address is rs + imm5
         opSt: begin
            aluOp     = aluAdd;
            bSrc      = bSrcImm5;
            memWrt    = 1'b1;
            memAccess = 1'b1;
         end
         opLd: begin
            aluOp     = aluAdd;
            bSrc      = bSrcImm5;
            readEn    = 1'b1;
            memAccess = 1'b1;
            wbSel     = wbMem;
            destSel   = destRt;
            regWrt    = 1'b1;
         end
         opStu: begin
            aluOp     = aluAdd;
            bSrc      = bSrcImm5;
            memWrt    = 1'b1;
            memAccess = 1'b1;
            stuSel    = 1'b1;
            destSel   = destRs;             // updated address back to rs
            regWrt    = 1'b1;
         end

         // byte immediates into rs
         opLbi: begin
            aluOp   = aluLbi;
            destSel = destRs;
            regWrt  = 1'b1;
         end
         opSlbi: begin
            aluOp   = aluSlbi;
            zeroExt = 1'b1;
            slbiSel = 1'b1;
            destSel = destRs;
            regWrt  = 1'b1;
         end

         opBtr: begin
            aluOp  = aluBtr;
            regWrt = 1'b1;
         end

         // R-format groups, func picks the operation
         opArith: begin
            regWrt = 1'b1;
            case (instr.r.func)
               2'b00: aluOp = aluAdd;
               2'b01: begin
                  aluOp = aluSub;           // rt - rs
                  invA  = 1'b1;
                  cin   = 1'b1;
               end
               2'b10: aluOp = aluXor;
               default: begin
                  aluOp = aluAndn;
                  invB  = 1'b1;
               end
            endcase
         end
         opShift: begin
            regWrt = 1'b1;
            case (instr.r.func)
               2'b00:   aluOp = aluRol;
               2'b01:   aluOp = aluSll;
               2'b10:   aluOp = aluRor;
               default: aluOp = aluSrl;
            endcase
         end

         // compares run rs - rt, sco needs the plain sum
         opSeq, opSlt, opSle, opSco: begin
            wbSel  = wbCond;
            regWrt = 1'b1;
            invB   = (instr.r.opcode != opSco);
            cin    = (instr.r.opcode != opSco);
            case (instr.r.opcode)
               opSeq:   aluOp = aluSeq;
               opSlt:   aluOp = aluSlt;
               opSle:   aluOp = aluSle;
               default: aluOp = aluSco;
            endcase
         end

         // branches test rs against zero, offset is imm8
         opBeqz, opBnez, opBltz, opBgez: begin
            branchInst = 1'b1;
            immSrc     = 1'b1;
            bSrc       = bSrcZero;
            case (instr.r.opcode)
               opBeqz:  brchSig = brEqz;
               opBnez:  brchSig = brNez;
               opBltz:  brchSig = brLtz;
               default: brchSig = brGez;
            endcase
         end

         // jumps are branchInst with brchSig none
         opJ, opJal: begin
            branchInst = 1'b1;
            bSrc       = bSrcImm11;          // pc-relative imm11
            if (instr.r.opcode == opJal) begin
               jalSel  = 1'b1;
               wbSel   = wbPc2;
               destSel = destLink;
               regWrt  = 1'b1;
            end
         end
         opJr, opJalr: begin
            branchInst = 1'b1;
            aluJmp     = 1'b1;               // target is rs + imm8
            immSrc     = 1'b1;
            bSrc       = bSrcZero;
            if (instr.r.opcode == opJalr) begin
               jalSel  = 1'b1;
               wbSel   = wbPc2;
               destSel = destLink;
               regWrt  = 1'b1;
            end
         end

         default: err = 1'b1;               // x or unknown word, nothing written
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [isaPkg::regIdxWidth-1:0] rdIdxA,
   input  logic [isaPkg::regIdxWidth-1:0] rdIdxB,
   input  logic [isaPkg::regIdxWidth-1:0] wrIdx,
   input  logic [isaPkg::wordWidth-1:0]   wrData,
   input  logic                           wrEn,    // already qualified by stall
   output logic [isaPkg::wordWidth-1:0]   rdA,
   output logic [isaPkg::wordWidth-1:0]   rdB
);

   import isaPkg::*;

   logic [wordWidth-1:0] regs [numRegs];

   // single write port
   always_ff @(posedge clk) begin
      if (rst) begin
         regs <= '{default: '0};            // every register starts at zero
      end else if (wrEn) begin
         regs[wrIdx] <= wrData;
      end
   end

   // reads see the stored value only, a same-cycle write shows up after the edge
   assign rdA = regs[rdIdxA];
   assign rdB = regs[rdIdxB];

endmodule

`default_nettype wire

// File: rtl/operandSelect.sv
`timescale 1ns/10ps
`default_nettype none

module operandSelect (
   input  isaPkg::instrT                  instr,
   input  logic [isaPkg::wordWidth-1:0]   rdA,      // rs value, inA at the top
   input  logic [isaPkg::wordWidth-1:0]   rdB,      // rt value
   input  ctrlPkg::bSrcT                  bSrc,
   input  logic                           zeroExt,
   input  ctrlPkg::destSelT               destSel,
   input  logic                           stuSel,
   output logic [isaPkg::wordWidth-1:0]   inB,
   output logic [isaPkg::wordWidth-1:0]   wrtData,  // store data
   output logic [isaPkg::wordWidth-1:0]   imm8,
   output logic [isaPkg::wordWidth-1:0]   imm11,
   output logic [isaPkg::regIdxWidth-1:0] wrtRegOut
);

   import isaPkg::*;
   import ctrlPkg::*;

   logic [wordWidth-1:0] imm5;
   logic [10:0]          offset11;

   // j-format offset sits under the iTwo view
   assign offset11 = {instr.iTwo.rs, instr.iTwo.imm8};

   // zero or sign extension, shared select for both short immediates
   assign imm5 = zeroExt ? {11'b0, instr.iOne.imm5}
                         : {{11{instr.iOne.imm5[4]}}, instr.iOne.imm5};
   assign imm8 = zeroExt ? {8'b0, instr.iTwo.imm8}
                         : {{8{instr.iTwo.imm8[7]}}, instr.iTwo.imm8};

   assign imm11 = {{5{offset11[10]}}, offset11};  // always signed

   // B operand mux
   always_comb begin
      case (bSrc)
         bSrcReg:   inB = rdB;
         bSrcImm5:  inB = imm5;
         bSrcImm11: inB = imm11;
         default:   inB = '0;
      endcase
   end

   assign wrtData = stuSel ? rdB : inB;  // stu stores rt, address goes through the ALU

   // destination index
   always_comb begin
      case (destSel)
         destRs:   wrtRegOut = instr.r.rs;
         destRt:   wrtRegOut = instr.iOne.rd;  // same bits as r.rt
         destRd:   wrtRegOut = instr.r.rd;
         default:  wrtRegOut = linkReg;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [isaPkg::wordWidth-1:0]   instruction,
   input  logic                           instrValid,   // one-cycle qualifier
   input  logic                           alignErrI,    // fetch misaligned
   input  logic                           alignErrM,    // data access misaligned
   input  logic                           stall,        // holds register writes only
   input  logic [isaPkg::wordWidth-1:0]   wbData,
   input  logic [isaPkg::regIdxWidth-1:0] wbReg,
   input  logic                           wbEn,
   output ctrlPkg::aluOpT                 aluOp,
   output ctrlPkg::wbSelT                 wbSel,
   output ctrlPkg::brchT                  brchSig,
   output logic                           regWrtOut,
   output logic                           memWrt,
   output logic                           readEn,
   output logic                           memAccess,
   output logic                           cin,
   output logic                           invA,
   output logic                           invB,
   output logic                           aluJmp,
   output logic                           immSrc,
   output logic                           jalSel,
   output logic                           slbiSel,
   output logic                           createDump,
   output logic                           branchInst,
   output logic                           err,
   output logic [isaPkg::wordWidth-1:0]   inA,
   output logic [isaPkg::wordWidth-1:0]   inB,
   output logic [isaPkg::wordWidth-1:0]   wrtData,
   output logic [isaPkg::wordWidth-1:0]   imm8,
   output logic [isaPkg::wordWidth-1:0]   imm11,
   output logic [isaPkg::regIdxWidth-1:0] wrtRegOut
);

   import isaPkg::*;

   instrT            instrRaw;   // incoming word, operand fields
   instrT            instrEff;   // what the decoder actually sees
   ctrlPkg::bSrcT    bSrc;
   ctrlPkg::destSelT destSel;
   logic             zeroExt;
   logic             stuSel;
   logic [wordWidth-1:0] rdB;

   assign instrRaw = instruction;

   // misalignment wins and forces halt, no valid strobe means nop
   assign instrEff = (alignErrI | alignErrM) ? '0
                   : instrValid              ? instruction
                   :                           nopWord;

   controlUnit controlUnit_inst (
      .instr(instrEff), .aluOp(aluOp), .bSrc(bSrc), .wbSel(wbSel), .destSel(destSel),
      .brchSig(brchSig), .zeroExt(zeroExt), .regWrt(regWrtOut), .memWrt(memWrt),
      .readEn(readEn), .memAccess(memAccess), .stuSel(stuSel), .cin(cin), .invA(invA),
      .invB(invB), .aluJmp(aluJmp), .immSrc(immSrc), .jalSel(jalSel), .slbiSel(slbiSel),
      .createDump(createDump), .branchInst(branchInst), .err(err)
   );

   // write port gated by stall
   regFile regFile_inst (
      .clk(clk), .rst(rst), .rdIdxA(instrRaw.r.rs), .rdIdxB(instrRaw.r.rt), .wrIdx(wbReg),
      .wrData(wbData), .wrEn(wbEn & ~stall), .rdA(inA), .rdB(rdB)
   );

   operandSelect operandSelect_inst (
      .instr(instrRaw), .rdA(inA), .rdB(rdB), .bSrc(bSrc), .zeroExt(zeroExt),
      .destSel(destSel), .stuSel(stuSel), .inB(inB), .wrtData(wrtData), .imm8(imm8),
      .imm11(imm11), .wrtRegOut(wrtRegOut)
   );

endmodule

`default_nettype wire

// File: include/decodeVectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// columns: instruction, {valid, alignErrI, alignErrM, stall, wbEn}, wbReg, wbData,
//   then inA, inB, wrtData, wrtRegOut, aluOp, flags, imm8, imm11, misc (expected)
// flags: {regWrtOut, memWrt, err, readEn, createDump, branchInst, brchSig}
// misc: {wbSel, memAccess, cin, invA, invB, aluJmp, immSrc, jalSel, slbiSel}
task automatic loadVectors();
   addRow(16'h0000, 5'b00000, 3'd0, 16'h0000,                  // idle after reset
          16'h0000, 16'h0000, 16'h0000, 3'd0, 4'hf, 9'b000_000_000, 16'h0000, 16'h0000, 10'h000);
   // preload, each row reads the register it writes and sees the old value
   addRow(16'h0100, 5'b00001, 3'd1, dw[1],
          16'h0000, 16'h0000, 16'h0000, 3'd0, 4'hf, 9'b000_000_000, 16'h0000, 16'h0100, 10'h000);
   addRow(16'h0220, 5'b00001, 3'd2, dw[2],
          16'h0000, dw[1], dw[1], 3'd0, 4'hf, 9'b000_000_000, 16'h0020, 16'h0220, 10'h000);
   addRow(16'h0340, 5'b00001, 3'd3, dw[3],
          16'h0000, dw[2], dw[2], 3'd0, 4'hf, 9'b000_000_000, 16'h0040, 16'h0340, 10'h000);
   addRow(16'h0460, 5'b00001, 3'd4, dw[4],
          16'h0000, dw[3], dw[3], 3'd0, 4'hf, 9'b000_000_000, 16'h0060, 16'hfc60, 10'h000);
   // add r3, r1, r2 while a stalled write hits r1
   addRow(16'hd94c, 5'b10011, 3'd1, ~dw[1],
          dw[1], dw[2], dw[2], 3'd3, 4'h0, 9'b100_000_000, 16'h004c, 16'h014c, 10'h000);
   addRow(16'hd94d, 5'b10000, 3'd0, 16'h0000,                  // sub r3, r1, r2, r1 unchanged
          dw[1], dw[2], dw[2], 3'd3, 4'h1, 9'b100_000_000, 16'h004d, 16'h014d, 10'h060);
   addRow(16'h42bc, 5'b10000, 3'd0, 16'h0000,                  // addi, imm5 = -4
          dw[2], 16'hfffc, 16'hfffc, 3'd5, 4'h0, 9'b100_000_000, 16'hffbc, 16'h02bc, 10'h000);
   addRow(16'h52bc, 5'b10000, 3'd0, 16'h0000,                  // xori zero-extends
          dw[2], 16'h001c, 16'h001c, 3'd5, 4'h2, 9'b100_000_000, 16'h00bc, 16'h02bc, 10'h000);
   addRow(16'h5abc, 5'b10000, 3'd0, 16'h0000,                  // andni, inverted B
          dw[2], 16'h001c, 16'h001c, 3'd5, 4'h3, 9'b100_000_000, 16'h00bc, 16'h02bc, 10'h010);
   addRow(16'h93f0, 5'b10000, 3'd0, 16'h0000,                  // slbi, imm8 zero-extended
          dw[3], 16'h0000, 16'h0000, 3'd3, 4'he, 9'b100_000_000, 16'h00f0, 16'h03f0, 10'h001);
   addRow(16'h2404, 5'b10000, 3'd0, 16'h0000,                  // j, negative offset
          dw[4], 16'hfc04, 16'hfc04, 3'd1, 4'hf, 9'b000_001_000, 16'h0004, 16'hfc04, 10'h000);
   addRow(16'h8143, 5'b10000, 3'd0, 16'h0000,                  // st
          dw[1], 16'h0003, 16'h0003, 3'd0, 4'h0, 9'b010_000_000, 16'h0043, 16'h0143, 10'h080);
   addRow(16'h89c2, 5'b10000, 3'd0, 16'h0000,                  // ld into bits 7..5
          dw[1], 16'h0002, 16'h0002, 3'd6, 4'h0, 9'b100_100_000, 16'hffc2, 16'h01c2, 10'h180);
   addRow(16'h9a81, 5'b10000, 3'd0, 16'h0000,                  // stu stores rt, writes rs
          dw[2], 16'h0001, dw[4], 3'd2, 4'h0, 9'b110_000_000, 16'hff81, 16'h0281, 10'h080);
   addRow(16'h3010, 5'b10000, 3'd0, 16'h0000,                  // jal
          16'h0000, 16'h0010, 16'h0010, 3'd7, 4'hf, 9'b100_001_000, 16'h0010, 16'h0010, 10'h202);
   addRow(16'h3b08, 5'b10000, 3'd0, 16'h0000,                  // jalr
          dw[3], 16'h0000, 16'h0000, 3'd7, 4'hf, 9'b100_001_000, 16'h0008, 16'h0308, 10'h20e);
   addRow(16'h6cfe, 5'b10000, 3'd0, 16'h0000,                  // bnez
          dw[4], 16'h0000, 16'h0000, 3'd7, 4'hf, 9'b000_001_010, 16'hfffe, 16'hfcfe, 10'h004);
   addRow(16'h6104, 5'b10000, 3'd0, 16'h0000,                  // beqz
          dw[1], 16'h0000, 16'h0000, 3'd1, 4'hf, 9'b000_001_001, 16'h0004, 16'h0104, 10'h004);
   addRow(16'h1000, 5'b10000, 3'd0, 16'h0000,                  // siic is illegal here
          16'h0000, 16'h0000, 16'h0000, 3'd0, 4'hf, 9'b001_000_000, 16'h0000, 16'h0000, 10'h000);
   addRow(16'hd94c, 5'b11000, 3'd0, 16'h0000,                  // fetch misaligned, halt
          dw[1], dw[2], dw[2], 3'd3, 4'hf, 9'b000_010_000, 16'h004c, 16'h014c, 10'h000);
   addRow(16'h0000, 5'b00100, 3'd0, 16'h0000,                  // data misaligned, no valid
          16'h0000, 16'h0000, 16'h0000, 3'd0, 4'hf, 9'b000_010_000, 16'h0000, 16'h0000, 10'h000);
endtask

`endif

// File: tb/decodeStageTb.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb;

   import isaPkg::*;
   import ctrlPkg::*;

   localparam int clkPeriod   = 4;
   localparam int resetCycles = 4;

   typedef struct packed {
      logic [wordWidth-1:0]   instr;
      logic [4:0]             ctl;      // valid, alignErrI, alignErrM, stall, wbEn
      logic [regIdxWidth-1:0] wbReg;
      logic [wordWidth-1:0]   wbData;
      logic [wordWidth-1:0]   inA;
      logic [wordWidth-1:0]   inB;
      logic [wordWidth-1:0]   wrtData;
      logic [regIdxWidth-1:0] wrtReg;
      logic [3:0]             aluOp;
      logic [8:0]             flags;    // regWrt, memWrt, err, readEn, dump, branch, brch
      logic [wordWidth-1:0]   imm8;
      logic [wordWidth-1:0]   imm11;
      logic [9:0]             misc;     // wbSel, memAccess, cin, invA, invB, aluJmp, immSrc, jal, slbi
   } vecT;

   // DUT ports, same names so the instance can use .*
   logic clk, rst, instrValid, alignErrI, alignErrM, stall, wbEn;
   logic [wordWidth-1:0]   instruction, wbData;
   logic [regIdxWidth-1:0] wbReg;
   aluOpT aluOp;
   wbSelT wbSel;
   brchT  brchSig;
   logic regWrtOut, memWrt, readEn, memAccess, cin, invA, invB, aluJmp;
   logic immSrc, jalSel, slbiSel, createDump, branchInst, err;
   logic [wordWidth-1:0]   inA, inB, wrtData, imm8, imm11;
   logic [regIdxWidth-1:0] wrtRegOut;

   vecT                  vecs [$];
   logic [wordWidth-1:0] dw [$];     // random register contents
   logic [31:0]          rnd;
   int                   seed;
   int                   rowIdx;

   decodeStage decodeStage_inst (.*);

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   task automatic addRow(input logic [15:0] instr, input logic [4:0] ctl,
                         input logic [2:0] wReg, input logic [15:0] wData,
                         input logic [15:0] expA, input logic [15:0] expB,
                         input logic [15:0] expWd, input logic [2:0] expReg,
                         input logic [3:0] expOp, input logic [8:0] expFlags,
                         input logic [15:0] expImm8, input logic [15:0] expImm11,
                         input logic [9:0] expMisc);
      vecs.push_back({instr, ctl, wReg, wData, expA, expB, expWd, expReg, expOp,
                      expFlags, expImm8, expImm11, expMisc});
   endtask

   `include "decodeVectors.svh"

   task automatic checkValue(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s row %0d: got 0x%h, expected 0x%h", name, rowIdx, got, exp);
         $display("TEST FAILED");
         $fatal(1, "decode output wrong");
      end
   endtask

   task automatic applyRow(input vecT v);
      instruction = v.instr;
      {instrValid, alignErrI, alignErrM, stall, wbEn} = v.ctl;
      wbReg  = v.wbReg;
      wbData = v.wbData;       // lands at the next edge
   endtask

   task automatic checkRow(input vecT v);
      checkValue("inA", inA, v.inA);
      checkValue("inB", inB, v.inB);
      checkValue("wrtData", wrtData, v.wrtData);
      checkValue("wrtRegOut", {13'b0, wrtRegOut}, {13'b0, v.wrtReg});
      checkValue("aluOp", {12'b0, aluOp}, {12'b0, v.aluOp});
      checkValue("regWrtOut", {15'b0, regWrtOut}, {15'b0, v.flags[8]});
      checkValue("memWrt", {15'b0, memWrt}, {15'b0, v.flags[7]});
      checkValue("err", {15'b0, err}, {15'b0, v.flags[6]});
      checkValue("readEn", {15'b0, readEn}, {15'b0, v.flags[5]});
      checkValue("createDump", {15'b0, createDump}, {15'b0, v.flags[4]});
      checkValue("branchInst", {15'b0, branchInst}, {15'b0, v.flags[3]});
      checkValue("brchSig", {13'b0, brchSig}, {13'b0, v.flags[2:0]});
      checkValue("imm8", imm8, v.imm8);
      checkValue("imm11", imm11, v.imm11);
      checkValue("wbSel", {14'b0, wbSel}, {14'b0, v.misc[9:8]});
      checkValue("memAccess", {15'b0, memAccess}, {15'b0, v.misc[7]});
      checkValue("cin", {15'b0, cin}, {15'b0, v.misc[6]});
      checkValue("invA", {15'b0, invA}, {15'b0, v.misc[5]});
      checkValue("invB", {15'b0, invB}, {15'b0, v.misc[4]});
      checkValue("aluJmp", {15'b0, aluJmp}, {15'b0, v.misc[3]});
      checkValue("immSrc", {15'b0, immSrc}, {15'b0, v.misc[2]});
      checkValue("jalSel", {15'b0, jalSel}, {15'b0, v.misc[1]});
      checkValue("slbiSel", {15'b0, slbiSel}, {15'b0, v.misc[0]});
   endtask

   initial begin
      seed        = 21;
      rowIdx      = 0;
      rst         = 1'b1;
      instruction = '0;
      instrValid  = 1'b0;
      alignErrI   = 1'b0;
      alignErrM   = 1'b0;
      stall       = 1'b0;
      wbEn        = 1'b0;
      wbReg       = '0;
      wbData      = '0;
      repeat (8) begin
         rnd = $random(seed);
         dw.push_back(rnd[15:0]);
      end
      loadVectors();               // table refers to dw
      repeat (resetCycles) @(posedge clk);
      #1;
      rst = 1'b0;
      foreach (vecs[i]) begin
         rowIdx = i;
         applyRow(vecs[i]);
         #2;                       // just before the next rising edge
         checkRow(vecs[i]);
         @(posedge clk);
         #1;
      end
      $display("TEST PASSED");
      $finish;
   end

   // table length plus reset plus some slack
   initial begin
      #1;
      #((vecs.size() + resetCycles + 8) * clkPeriod);
      $display("timeout: the decode table did not finish in the expected time");
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// File: decodeStage.f
+incdir+include
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/controlUnit.sv
rtl/regFile.sv
rtl/operandSelect.sv
rtl/decodeStage.sv
tb/decodeStageTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := decodeStageTb
FILELIST  := decodeStage.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/decodeVectors.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
